/* hw/ex_ft_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types and constants for the fault-tolerant execute stage
// import into the module body, use scoped names in port lists
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ex_ft_pkg;

  // datapath width and register-file write address
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 6;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // four ALU copies, one of them held back as spare
  localparam int NUM_COPIES = 4;

  typedef logic [$clog2(NUM_COPIES)-1:0] copy_idx_t;
  typedef logic [NUM_COPIES-1:0]         copy_mask_t;

  // ALU operator encoding
  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    AND  = 3'd2,
    OR   = 3'd3,
    XOR  = 3'd4,
    SLT  = 3'd5,
    SLTU = 3'd6,
    EQ   = 3'd7
  } alu_op_e;

  // per-copy corrected-error counters
  localparam int FAULT_CNT_W = 9;

  typedef logic [FAULT_CNT_W-1:0] fault_cnt_t;

  // count at which a copy is declared permanently faulty
  localparam fault_cnt_t FAULT_THRESHOLD = 9'd8;

endpackage

`default_nettype wire

/* hw/alu_core.sv */
//////////////////////////////////////////////////////////////////////
// single combinational integer ALU copy, replicated inside alu_ft
//////////////////////////////////////////////////////////////////////

`default_nettype none

module alu_core (
  input  ex_ft_pkg::alu_op_e operator_i,
  input  ex_ft_pkg::word_t   operand_a_i,
  input  ex_ft_pkg::word_t   operand_b_i,
  output ex_ft_pkg::word_t   result_o,
  output logic               cmp_o
);

  import ex_ft_pkg::*;

  always_comb begin
    // cmp only meaningful for the compare ops
    result_o = '0;
    cmp_o    = 1'b0;
    case (operator_i)
      ADD: result_o = operand_a_i + operand_b_i;
      SUB: result_o = operand_a_i - operand_b_i;
      AND: result_o = operand_a_i & operand_b_i;
      OR:  result_o = operand_a_i | operand_b_i;
      XOR: result_o = operand_a_i ^ operand_b_i;
      SLT: begin
        // signed less-than
        cmp_o    = $signed(operand_a_i) < $signed(operand_b_i);
        result_o = word_t'(cmp_o);
      end
      SLTU: begin
        cmp_o    = operand_a_i < operand_b_i;
        result_o = word_t'(cmp_o);
      end
      EQ: begin
        // used by the branch unit for beq/bne
        cmp_o    = operand_a_i == operand_b_i;
        result_o = word_t'(cmp_o);
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/tmr_voter.sv */
//////////////////////////////////////////////////////////////////////
// 2-of-3 majority voter, payload type set by parameter T
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tmr_voter #(
  parameter type T = logic
) (
  input  T           in_a_i,
  input  T           in_b_i,
  input  T           in_c_i,
  output T           voted_o,
  output logic [2:0] mismatch_o,
  output logic       err_corrected_o,
  output logic       err_detected_o
);

  // pairwise agreement
  logic ab_eq;
  logic ac_eq;
  logic bc_eq;

  assign ab_eq = (in_a_i == in_b_i);
  assign ac_eq = (in_a_i == in_c_i);
  assign bc_eq = (in_b_i == in_c_i);

  always_comb begin
    // first input wins when nothing agrees
    voted_o        = in_a_i;
    mismatch_o     = 3'b000;
    err_detected_o = 1'b0;
    if (ab_eq && ac_eq) begin
      // all three agree
      voted_o = in_a_i;
    end else if (ab_eq) begin
      mismatch_o[2] = 1'b1;
    end else if (ac_eq) begin
      mismatch_o[1] = 1'b1;
    end else if (bc_eq) begin
      voted_o       = in_b_i;
      mismatch_o[0] = 1'b1;
    end else begin
      err_detected_o = 1'b1;
    end
  end

  // a majority exists and exactly one input is outvoted
  assign err_corrected_o = |mismatch_o;

endmodule

`default_nettype wire

/* hw/fault_tracker.sv */
//////////////////////////////////////////////////////////////////////
// corrected-error counters and sticky permanent-fault flags per copy
// counts only on retired ALU operations, readable by copy index
//////////////////////////////////////////////////////////////////////

`default_nettype none

module fault_tracker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 count_en_i,
  input  ex_ft_pkg::copy_mask_t mismatch_i,
  output ex_ft_pkg::copy_mask_t permanent_o,
  input  ex_ft_pkg::copy_idx_t  cnt_sel_i,
  output ex_ft_pkg::fault_cnt_t cnt_o
);

  import ex_ft_pkg::*;

  fault_cnt_t cnt_q [NUM_COPIES];
  fault_cnt_t cnt_d [NUM_COPIES];
  copy_mask_t perm_q;
  copy_mask_t perm_d;

  //////////////////////////////////////////////////////////////////////
  // next-state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_COPIES; i++) begin
      cnt_d[i] = cnt_q[i];
      // saturate at all ones
      if (count_en_i && mismatch_i[i] && !(&cnt_q[i])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // flag goes up on the same edge the count hits threshold
      perm_d[i] = perm_q[i] | (cnt_d[i] == FAULT_THRESHOLD);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_COPIES; i++) begin
        cnt_q[i] <= '0;
      end
      perm_q <= '0;
    end else begin
      for (int i = 0; i < NUM_COPIES; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
      perm_q <= perm_d;
    end
  end

  assign permanent_o = perm_q;

  // read port for one counter
  assign cnt_o = cnt_q[cnt_sel_i];

endmodule

`default_nettype wire

/* hw/alu_ft.sv */
//////////////////////////////////////////////////////////////////////
// four ALU copies, one spare, result and compare bit voted 2-of-3
// spare_sel_i names the copy left out of the vote
//////////////////////////////////////////////////////////////////////

`default_nettype none

module alu_ft (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        enable_i,
  input  logic                                        ex_ready_i,
  input  ex_ft_pkg::alu_op_e [ex_ft_pkg::NUM_COPIES-1:0] operator_i,
  input  ex_ft_pkg::word_t   [ex_ft_pkg::NUM_COPIES-1:0] operand_a_i,
  input  ex_ft_pkg::word_t   [ex_ft_pkg::NUM_COPIES-1:0] operand_b_i,
  input  ex_ft_pkg::copy_idx_t                        spare_sel_i,
  output ex_ft_pkg::word_t                            result_o,
  output logic                                        cmp_o,
  output logic                                        err_corrected_o,
  output logic                                        err_detected_o,
  output ex_ft_pkg::copy_mask_t                       permanent_faulty_o,
  input  ex_ft_pkg::copy_idx_t                        fault_cnt_sel_i,
  output ex_ft_pkg::fault_cnt_t                       fault_cnt_o
);

  import ex_ft_pkg::*;

  word_t                 result_c [NUM_COPIES];
  logic [NUM_COPIES-1:0] cmp_c;
  // copy index feeding each voter input
  copy_idx_t             vote_idx [NUM_COPIES-1];
  logic [2:0]            res_mm;
  logic [2:0]            cmp_mm;
  logic                  res_corr;
  logic                  res_det;
  logic                  cmp_corr;
  copy_mask_t            copy_mm;
  logic                  retire;

  //////////////////////////////////////////////////////////////////////
  // ALU copies
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_COPIES; g++) begin : gen_copy
    alu_core alu_core_i (
      .operator_i  (operator_i[g]),
      .operand_a_i (operand_a_i[g]),
      .operand_b_i (operand_b_i[g]),
      .result_o    (result_c[g]),
      .cmp_o       (cmp_c[g])
    );
  end

  // skip over the spare and keep ascending order
  always_comb begin
    for (int k = 0; k < NUM_COPIES - 1; k++) begin
      vote_idx[k] = (k < int'(spare_sel_i)) ? copy_idx_t'(k) : copy_idx_t'(k + 1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // voting
  //////////////////////////////////////////////////////////////////////

  tmr_voter #(.T(word_t)) res_voter_i (
    .in_a_i          (result_c[vote_idx[0]]),
    .in_b_i          (result_c[vote_idx[1]]),
    .in_c_i          (result_c[vote_idx[2]]),
    .voted_o         (result_o),
    .mismatch_o      (res_mm),
    .err_corrected_o (res_corr),
    .err_detected_o  (res_det)
  );

  // three single bits always leave a majority, so no detect flag here
  tmr_voter #(.T(logic)) cmp_voter_i (
    .in_a_i          (cmp_c[vote_idx[0]]),
    .in_b_i          (cmp_c[vote_idx[1]]),
    .in_c_i          (cmp_c[vote_idx[2]]),
    .voted_o         (cmp_o),
    .mismatch_o      (cmp_mm),
    .err_corrected_o (cmp_corr),
    .err_detected_o  ()
  );

  // map voter slots back to physical copies and leave the spare bit clear
  always_comb begin
    copy_mm = '0;
    for (int k = 0; k < NUM_COPIES - 1; k++) begin
      copy_mm[vote_idx[k]] = res_mm[k] | cmp_mm[k];
    end
  end

  // op actually leaves EX this cycle
  assign retire = enable_i & ex_ready_i;

  assign err_corrected_o = retire & (res_corr | cmp_corr);
  assign err_detected_o  = retire & res_det;

  fault_tracker fault_tracker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .count_en_i  (retire),
    .mismatch_i  (copy_mm),
    .permanent_o (permanent_faulty_o),
    .cnt_sel_i   (fault_cnt_sel_i),
    .cnt_o       (fault_cnt_o)
  );

endmodule

`default_nettype wire

/* hw/ex_writeback.sv */
//////////////////////////////////////////////////////////////////////
// EX write ports: ALU/CSR forwarding port, registered load port,
// and the ex_ready / ex_valid stall control
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ex_writeback (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 alu_en_i,
  input  logic                 csr_access_i,
  input  logic                 lsu_en_i,
  input  ex_ft_pkg::word_t     alu_result_i,
  input  ex_ft_pkg::word_t     csr_rdata_i,
  input  ex_ft_pkg::word_t     lsu_rdata_i,
  input  ex_ft_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_ft_pkg::reg_addr_t regfile_waddr_i,
  input  logic                 regfile_alu_we_i,
  input  logic                 regfile_we_i,
  input  logic                 branch_in_ex_i,
  input  logic                 lsu_ready_i,
  input  logic                 lsu_err_i,
  input  logic                 wb_ready_i,
  output ex_ft_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic                 regfile_alu_we_fw_o,
  output ex_ft_pkg::word_t     regfile_alu_wdata_fw_o,
  output ex_ft_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic                 regfile_we_wb_o,
  output ex_ft_pkg::word_t     regfile_wdata_wb_o,
  output logic                 ex_ready_o,
  output logic                 ex_valid_o
);

  logic load_wr;

  // forwarding port, CSR read data overrides the ALU
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_wdata_fw_o = csr_access_i ? csr_rdata_i : alu_result_i;

  // branches finish in EX, so they never wait on WB
  assign ex_ready_o = (lsu_ready_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | csr_access_i | lsu_en_i) & lsu_ready_i & wb_ready_i;

  // bus error kills the load write
  assign load_wr = ex_valid_o & regfile_we_i & ~lsu_err_i;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= load_wr;
    end else if (wb_ready_i) begin
      // nothing new arriving, drain the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_wr) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

  // load data arrives in WB straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

`default_nettype wire

/* hw/ex_stage_ft.sv */
//////////////////////////////////////////////////////////////////////
// fault-tolerant execute stage top: voted ALU plus write-back logic
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ex_stage_ft (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  ex_ft_pkg::alu_op_e [ex_ft_pkg::NUM_COPIES-1:0] alu_operator_i,
  input  ex_ft_pkg::word_t   [ex_ft_pkg::NUM_COPIES-1:0] alu_operand_a_i,
  input  ex_ft_pkg::word_t   [ex_ft_pkg::NUM_COPIES-1:0] alu_operand_b_i,
  input  logic                                        alu_en_i,
  input  ex_ft_pkg::copy_idx_t                        spare_sel_i,
  input  logic                                        csr_access_i,
  input  ex_ft_pkg::word_t                            csr_rdata_i,
  input  logic                                        lsu_en_i,
  input  ex_ft_pkg::word_t                            lsu_rdata_i,
  input  ex_ft_pkg::reg_addr_t                        regfile_alu_waddr_i,
  input  logic                                        regfile_alu_we_i,
  input  ex_ft_pkg::reg_addr_t                        regfile_waddr_i,
  input  logic                                        regfile_we_i,
  input  logic                                        branch_in_ex_i,
  input  logic                                        lsu_ready_i,
  input  logic                                        lsu_err_i,
  input  logic                                        wb_ready_i,
  output ex_ft_pkg::reg_addr_t                        regfile_alu_waddr_fw_o,
  output logic                                        regfile_alu_we_fw_o,
  output ex_ft_pkg::word_t                            regfile_alu_wdata_fw_o,
  output ex_ft_pkg::reg_addr_t                        regfile_waddr_wb_o,
  output logic                                        regfile_we_wb_o,
  output ex_ft_pkg::word_t                            regfile_wdata_wb_o,
  output logic                                        branch_decision_o,
  output logic                                        ex_ready_o,
  output logic                                        ex_valid_o,
  output logic                                        err_corrected_o,
  output logic                                        err_detected_o,
  output ex_ft_pkg::copy_mask_t                       permanent_faulty_o,
  input  ex_ft_pkg::copy_idx_t                        fault_cnt_sel_i,
  output ex_ft_pkg::fault_cnt_t                       fault_cnt_o
);

  import ex_ft_pkg::*;

  // voted ALU result into the forwarding mux
  word_t alu_result;

  alu_ft alu_ft_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .enable_i           (alu_en_i),
    // counters only advance when the stage retires
    .ex_ready_i         (ex_ready_o),
    .operator_i         (alu_operator_i),
    .operand_a_i        (alu_operand_a_i),
    .operand_b_i        (alu_operand_b_i),
    .spare_sel_i        (spare_sel_i),
    .result_o           (alu_result),
    .cmp_o              (branch_decision_o),
    .err_corrected_o    (err_corrected_o),
    .err_detected_o     (err_detected_o),
    .permanent_faulty_o (permanent_faulty_o),
    .fault_cnt_sel_i    (fault_cnt_sel_i),
    .fault_cnt_o        (fault_cnt_o)
  );

  ex_writeback ex_writeback_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_we_i           (regfile_we_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .lsu_ready_i            (lsu_ready_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

/* tests/tb_ex_stage_ft.sv */
//////////////////////////////////////////////////////////////////////
// self-checking testbench for the fault-tolerant execute stage
// random ALU traffic, injected copy faults, write ports, stalls
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_ex_stage_ft;

  timeunit 1ns;
  timeprecision 1ps;

  import ex_ft_pkg::*;

  // cycles per test phase
  localparam int RESET_CYCLES = 10;
  localparam int N_CLEAN      = 200;
  localparam int N_CORR       = 60;
  localparam int N_SPARE      = 40;
  localparam int N_DETECT     = 30;
  localparam int N_SAT        = 520;
  localparam int N_PORTS      = 150;
  localparam int N_BP         = 150;
  localparam int N_MOVE       = 40;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + N_CLEAN + N_CORR + N_SPARE + N_DETECT
                                + N_SAT + N_PORTS + N_BP + 2 * N_MOVE + 20;

  logic clk, rst_n;
  alu_op_e [NUM_COPIES-1:0] alu_operator;
  word_t [NUM_COPIES-1:0] alu_operand_a, alu_operand_b;
  logic alu_en, csr_access, lsu_en, regfile_alu_we, regfile_we;
  logic branch_in_ex, lsu_ready, lsu_err, wb_ready;
  copy_idx_t spare_sel, fault_cnt_sel;
  word_t csr_rdata, lsu_rdata;
  reg_addr_t regfile_alu_waddr, regfile_waddr;
  // DUT outputs
  reg_addr_t fw_waddr, wb_waddr;
  logic fw_we, wb_we, branch_decision, ex_ready, ex_valid;
  logic err_corrected, err_detected;
  word_t fw_wdata, wb_wdata;
  copy_mask_t permanent_faulty;
  fault_cnt_t fault_cnt;

  // reference state updated once per cycle after the checks
  fault_cnt_t exp_cnt [NUM_COPIES];
  copy_mask_t exp_perm, perm_seen;
  logic exp_we;
  reg_addr_t exp_waddr;
  int errors, checks, cycles;
  logic [31:0] rng;

  ex_stage_ft dut_i (
    .clk (clk), .rst_n (rst_n),
    .alu_operator_i (alu_operator), .alu_operand_a_i (alu_operand_a),
    .alu_operand_b_i (alu_operand_b), .alu_en_i (alu_en), .spare_sel_i (spare_sel),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata), .lsu_en_i (lsu_en),
    .lsu_rdata_i (lsu_rdata), .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_alu_we_i (regfile_alu_we), .regfile_waddr_i (regfile_waddr),
    .regfile_we_i (regfile_we), .branch_in_ex_i (branch_in_ex), .lsu_ready_i (lsu_ready),
    .lsu_err_i (lsu_err), .wb_ready_i (wb_ready),
    .regfile_alu_waddr_fw_o (fw_waddr), .regfile_alu_we_fw_o (fw_we),
    .regfile_alu_wdata_fw_o (fw_wdata), .regfile_waddr_wb_o (wb_waddr),
    .regfile_we_wb_o (wb_we), .regfile_wdata_wb_o (wb_wdata),
    .branch_decision_o (branch_decision), .ex_ready_o (ex_ready), .ex_valid_o (ex_valid),
    .err_corrected_o (err_corrected), .err_detected_o (err_detected),
    .permanent_faulty_o (permanent_faulty), .fault_cnt_sel_i (fault_cnt_sel),
    .fault_cnt_o (fault_cnt)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b,
                                    output logic cmp);
    word_t r;
    r   = '0;
    cmp = 1'b0;
    case (op)
      ADD:  r = a + b;
      SUB:  r = a - b;
      AND:  r = a & b;
      OR:   r = a | b;
      XOR:  r = a ^ b;
      SLT:  cmp = $signed(a) < $signed(b);
      SLTU: cmp = a < b;
      EQ:   cmp = a == b;
    endcase
    // compares return the flag as a zero-extended word
    if (op == SLT || op == SLTU || op == EQ) begin
      r = {{(XLEN-1){1'b0}}, cmp};
    end
    return r;
  endfunction

  // majority of three with the first input winning when all differ
  function automatic word_t ref_vote(input word_t a, input word_t b, input word_t c,
                                     output logic [2:0] mm, output logic det);
    word_t v;
    mm  = 3'b000;
    det = 1'b0;
    if (a == b || a == c) begin
      v = a;
    end else if (b == c) begin
      v = b;
    end else begin
      v   = a;
      det = 1'b1;
    end
    if (!det) begin
      mm[0] = a != v;
      mm[1] = b != v;
      mm[2] = c != v;
    end
    return v;
  endfunction

  task automatic check_val(input string test, input string sig, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAIL %s %s: expected %0h, actual %0h", test, sig, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // step to the drive point just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
    // walk the counter read port over all copies
    fault_cnt_sel = fault_cnt_sel + 1'b1;
  endtask

  // same op on all copies; arith limits it to ops where an operand flip always shows
  task automatic load_op(input logic arith);
    logic [31:0] r;
    alu_op_e op;
    word_t a, b;
    r  = next_rand();
    op = alu_op_e'(r[2:0]);
    if (arith) begin
      op = (r[1:0] == 2'd0) ? ADD : (r[1:0] == 2'd1) ? SUB : XOR;
    end
    a = next_rand();
    // equal operands now and then so EQ comes out true
    b = (r[5:3] == 3'd0) ? a : next_rand();
    for (int i = 0; i < NUM_COPIES; i++) begin
      alu_operator[i]  = op;
      alu_operand_a[i] = a;
      alu_operand_b[i] = b;
    end
  endtask

  task automatic random_ctrl(input logic flow);
    logic [31:0] r;
    r                 = next_rand();
    csr_access        = r[0];
    lsu_en            = r[1];
    alu_en            = r[2] | r[3];
    regfile_we        = r[4];
    lsu_err           = r[5] & r[6];
    regfile_waddr     = r[12:7];
    regfile_alu_waddr = r[18:13];
    regfile_alu_we    = r[19];
    csr_rdata         = next_rand();
    lsu_rdata         = next_rand();
    if (flow) begin
      wb_ready     = r[20] | r[21];
      lsu_ready    = r[22] | r[23] | r[24];
      branch_in_ex = r[25] & r[26];
    end
  endtask

  // compare every output with the model, then advance the model state
  task automatic check_cycle(input string test);
    word_t res [NUM_COPIES];
    word_t cmpw [NUM_COPIES];
    int vi [3];
    int n, idx;
    logic c, det_r, det_c, rdy, vld, retire, load_wr;
    logic [2:0] mm_r, mm_c;
    word_t v_res, v_cmp;
    n = 0;
    for (int i = 0; i < NUM_COPIES; i++) begin
      res[i]  = ref_alu(alu_operator[i], alu_operand_a[i], alu_operand_b[i], c);
      cmpw[i] = word_t'(c);
      if (i != int'(spare_sel)) begin
        vi[n] = i;
        n++;
      end
    end
    v_res  = ref_vote(res[vi[0]], res[vi[1]], res[vi[2]], mm_r, det_r);
    v_cmp  = ref_vote(cmpw[vi[0]], cmpw[vi[1]], cmpw[vi[2]], mm_c, det_c);
    rdy    = (lsu_ready & wb_ready) | branch_in_ex;
    vld    = (alu_en | csr_access | lsu_en) & lsu_ready & wb_ready;
    retire = alu_en & rdy;
    @(negedge clk);
    check_val(test, "fw_wdata", csr_access ? csr_rdata : v_res, fw_wdata);
    check_val(test, "fw_we", 32'(regfile_alu_we), 32'(fw_we));
    check_val(test, "fw_waddr", 32'(regfile_alu_waddr), 32'(fw_waddr));
    check_val(test, "branch", 32'(v_cmp[0]), 32'(branch_decision));
    check_val(test, "err_corrected", 32'(retire & ((|mm_r) | (|mm_c))), 32'(err_corrected));
    check_val(test, "err_detected", 32'(retire & (det_r | det_c)), 32'(err_detected));
    check_val(test, "ex_ready", 32'(rdy), 32'(ex_ready));
    check_val(test, "ex_valid", 32'(vld), 32'(ex_valid));
    check_val(test, "wb_we", 32'(exp_we), 32'(wb_we));
    if (exp_we) begin
      check_val(test, "wb_waddr", 32'(exp_waddr), 32'(wb_waddr));
    end
    check_val(test, "wb_wdata", lsu_rdata, wb_wdata);
    check_val(test, "permanent", 32'(exp_perm), 32'(permanent_faulty));
    check_val(test, "fault_cnt", 32'(exp_cnt[fault_cnt_sel]), 32'(fault_cnt));
    // EX/WB register of the load port
    load_wr = vld & regfile_we & ~lsu_err;
    if (vld) begin
      exp_we = load_wr;
    end else if (wb_ready) begin
      exp_we = 1'b0;
    end
    if (load_wr) begin
      exp_waddr = regfile_waddr;
    end
    // outvoted copies count on retire only and saturate
    for (int k = 0; k < 3; k++) begin
      idx = vi[k];
      if (retire && (mm_r[k] || mm_c[k]) && exp_cnt[idx] != '1) begin
        exp_cnt[idx]++;
      end
      if (exp_cnt[idx] == FAULT_THRESHOLD) begin
        exp_perm[idx] = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // sticky permanent flags and run limit
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      assert ((permanent_faulty & perm_seen) == perm_seen) else begin
        errors++;
        $display("a permanent fault flag dropped without reset");
      end
      perm_seen = perm_seen | permanent_faulty;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, test sequence did not finish", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    rng = 32'hed64_1f1b;
    errors = 0;
    checks = 0;
    cycles = 0;
    alu_operator = '0;
    alu_operand_a = '0;
    alu_operand_b = '0;
    alu_en = 1'b1;
    csr_access = 1'b0;
    lsu_en = 1'b0;
    regfile_alu_we = 1'b0;
    regfile_we = 1'b0;
    branch_in_ex = 1'b0;
    lsu_ready = 1'b1;
    lsu_err = 1'b0;
    wb_ready = 1'b1;
    spare_sel = 2'd3;
    fault_cnt_sel = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    regfile_alu_waddr = '0;
    regfile_waddr = '0;
    exp_perm = '0;
    perm_seen = '0;
    exp_we = 1'b0;
    exp_waddr = '0;
    for (int i = 0; i < NUM_COPIES; i++) begin
      exp_cnt[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int i = 0; i < N_CLEAN; i++) begin
      next_cycle();
      load_op(1'b0);
      check_cycle("clean");
    end
    // one voted copy wrong at a time
    for (int i = 0; i < N_CORR; i++) begin
      next_cycle();
      load_op(1'b1);
      alu_operand_a[i % 3] = alu_operand_a[i % 3] ^ 32'h1;
      check_cycle("correct");
    end
    for (int i = 0; i < N_SPARE; i++) begin
      next_cycle();
      load_op(1'b1);
      alu_operand_a[3] = alu_operand_a[3] ^ 32'h1;
      check_cycle("spare");
    end
    // three different results among the voted copies
    for (int i = 0; i < N_DETECT; i++) begin
      next_cycle();
      load_op(1'b1);
      alu_operand_a[1] = alu_operand_a[1] ^ 32'h1;
      alu_operand_a[2] = alu_operand_a[2] ^ 32'h2;
      check_cycle("detect");
    end
    // past threshold and into saturation on copy 1
    for (int i = 0; i < N_SAT; i++) begin
      next_cycle();
      load_op(1'b1);
      alu_operand_a[1] = alu_operand_a[1] ^ 32'h1;
      check_cycle("saturate");
    end
    for (int i = 0; i < N_PORTS; i++) begin
      next_cycle();
      load_op(1'b0);
      random_ctrl(1'b0);
      check_cycle("ports");
    end
    for (int i = 0; i < N_BP; i++) begin
      next_cycle();
      load_op(1'b1);
      alu_operand_a[2] = alu_operand_a[2] ^ 32'h1;
      random_ctrl(1'b1);
      check_cycle("backpressure");
    end
    // copy 0 leaves the vote and copy 3 joins it
    for (int i = 0; i < 2 * N_MOVE; i++) begin
      next_cycle();
      alu_en = 1'b1;
      csr_access = 1'b0;
      wb_ready = 1'b1;
      lsu_ready = 1'b1;
      branch_in_ex = 1'b0;
      spare_sel = 2'd0;
      load_op(1'b1);
      if (i < N_MOVE) begin
        alu_operand_a[0] = alu_operand_a[0] ^ 32'h1;
      end else begin
        alu_operand_a[3] = alu_operand_a[3] ^ 32'h1;
      end
      check_cycle("spare_moved");
    end

    $display("run complete: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/ex_ft_pkg.sv
hw/alu_core.sv
hw/tmr_voter.sv
hw/fault_tracker.sv
hw/alu_ft.sv
hw/ex_writeback.sv
hw/ex_stage_ft.sv
tests/tb_ex_stage_ft.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_ex_stage_ft
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
